/* tb.f */
+incdir+logic
logic/fpga_io_pkg.sv
logic/board_registers.sv
logic/uart_transmitter.sv
logic/uart_receiver.sv
logic/uart_port.sv
logic/fpga_io_top.sv
test/fpga_io_checker.sv
test/fpga_io_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= fpga_io_tb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

/* test/fpga_io_tb.sv */
`timescale 1ns/100ps
`include "fpga_io_macros.svh"

module fpga_io_tb;

	logic clk50;
	logic core_reset;
	fpga_io_pkg::io_req_t io_req;
	logic [`IO_DATA_WIDTH-1:0] io_read_data;
	logic [`RED_LED_WIDTH-1:0] red_led;
	logic [`GREEN_LED_WIDTH-1:0] green_led;
	logic [`HEX_WIDTH-1:0] hex0;
	logic [`HEX_WIDTH-1:0] hex1;
	logic [`HEX_WIDTH-1:0] hex2;
	logic [`HEX_WIDTH-1:0] hex3;
	logic uart_tx;
	logic uart_rx;
	integer seed;
	int errors;
	int timeouts;

	localparam logic [`IO_ADDR_WIDTH-1:0] display_addr [6] = '{`ADDR_RED_LED,
		`ADDR_GREEN_LED, `ADDR_HEX0, `ADDR_HEX1, `ADDR_HEX2, `ADDR_HEX3};
	localparam int display_width [6] = '{`RED_LED_WIDTH, `GREEN_LED_WIDTH, `HEX_WIDTH,
		`HEX_WIDTH, `HEX_WIDTH, `HEX_WIDTH};
	string display_name [6] = '{"red_led", "green_led", "hex0", "hex1", "hex2", "hex3"};

	fpga_io_top dut0(.*);

	initial
	begin
		clk50 = 1'b0;
		forever #5 clk50 = ~clk50;    // 100 MHz sim clock with a 10 ns period
	end

	task automatic compare_word(input string name, input logic [`IO_DATA_WIDTH-1:0] expected,
		input logic [`IO_DATA_WIDTH-1:0] actual);
		if (actual !== expected)
		begin
			$display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic compare_display(input string name,
		input logic [`RED_LED_WIDTH-1:0] expected, input logic [`RED_LED_WIDTH-1:0] actual);
		if (actual !== expected)
		begin
			$display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic compare_serial_byte(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected)
		begin
			$display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic end_run();
		$display("Errors: %0d, assertion failures: %0d, timeouts: %0d", errors,
			dut0.checker0.failures, timeouts);
		if (errors == 0 && timeouts == 0 && dut0.checker0.failures == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	endtask

	// One-cycle write strobe that lands on the edge in between
	task automatic bus_write(input logic [`IO_ADDR_WIDTH-1:0] addr,
		input logic [`IO_DATA_WIDTH-1:0] data);
		@(negedge clk50);
		io_req.write_en = 1'b1;
		io_req.address = addr;
		io_req.write_data = data;
		@(negedge clk50);
		io_req = '0;
	endtask

	// Combinational read sampled just after the falling edge
	task automatic bus_read(input logic [`IO_ADDR_WIDTH-1:0] addr,
		output logic [`IO_DATA_WIDTH-1:0] data);
		@(negedge clk50);
		io_req.read_en = 1'b1;
		io_req.address = addr;
		#1 data = io_read_data;
		@(negedge clk50);
		io_req = '0;
	endtask

	// Polls the status word until a masked bit is set
	task automatic wait_status(input logic [1:0] mask, input string what);
		logic [`IO_DATA_WIDTH-1:0] word;
		int polls;
		polls = 0;
		word = '0;
		while ((word[1:0] & mask) == 2'b00 && polls < 400)
		begin
			bus_read(`ADDR_UART_STATUS, word);
			polls++;
		end
		if ((word[1:0] & mask) == 2'b00)
		begin
			$display("Timed out waiting for %s in the UART status word", what);
			timeouts++;
		end
	endtask

	// 8N1 frame at 27 clocks per bit with a selectable stop level
	task automatic send_frame(input logic [7:0] data, input logic stop_level);
		logic [9:0] frame;
		int bit_num;
		frame = {stop_level, data, 1'b0};
		@(negedge clk50);
		for (bit_num = 0; bit_num < 10; bit_num++)
		begin
			uart_rx = frame[bit_num];    // Start bit goes out ahead of the LSB
			repeat (`UART_BIT_CLOCKS) @(negedge clk50);
		end
		uart_rx = 1'b1;
	endtask

	function automatic logic [`RED_LED_WIDTH-1:0] display_value(input int idx);
		case (idx)
			0: return red_led;
			1: return `RED_LED_WIDTH'(green_led);
			2: return `RED_LED_WIDTH'(hex0);
			3: return `RED_LED_WIDTH'(hex1);
			4: return `RED_LED_WIDTH'(hex2);
			default: return `RED_LED_WIDTH'(hex3);
		endcase
	endfunction

	task automatic test_reset();
		logic [`IO_DATA_WIDTH-1:0] word;
		int i;
		for (i = 0; i < 6; i++)
			compare_display(display_name[i], '0, display_value(i));
		compare_word("uart_tx", 32'd1, {31'd0, uart_tx});
		bus_read(`ADDR_UART_STATUS, word);
		compare_word("status after reset", 32'd1, word);    // tx_ready only
	endtask

	task automatic test_display();
		logic [`IO_DATA_WIDTH-1:0] value;
		logic [`IO_DATA_WIDTH-1:0] word;
		logic [`RED_LED_WIDTH-1:0] expected [6];
		int i;
		for (i = 0; i < 6; i++)
		begin
			value = $random(seed);
			expected[i] = `RED_LED_WIDTH'(value & ((32'd1 << display_width[i]) - 32'd1));
			bus_write(display_addr[i], value);
			compare_display(display_name[i], expected[i], display_value(i));
		end
		bus_write(32'h20, 32'hFFFF_FFFF);    // Gap below the timer
		bus_write(32'h40, 32'hFFFF_FFFF);    // Past the map
		for (i = 0; i < 6; i++)
			compare_display(display_name[i], expected[i], display_value(i));
		bus_read(32'h20, word);
		compare_word("read of 0x20", '0, word);
		bus_read(32'h100, word);
		compare_word("read of 0x100", '0, word);
	endtask

	task automatic test_timer();
		logic [`IO_DATA_WIDTH-1:0] first;
		logic [`IO_DATA_WIDTH-1:0] second;
		int k;
		int trial;
		for (trial = 0; trial < 3; trial++)
		begin
			k = 4 + ($random(seed) & 63);
			bus_read(`ADDR_TIMER, first);
			repeat (k - 2) @(negedge clk50);    // Read spends one more edge before sampling
			bus_read(`ADDR_TIMER, second);
			compare_word("timer delta", k, second - first);
		end
	endtask

	task automatic test_uart_tx();
		logic [7:0] sent;
		logic [7:0] seen;
		logic [`IO_DATA_WIDTH-1:0] word;
		int bit_num;
		sent = 8'($random(seed));
		bus_write(`ADDR_UART_DATA, {24'd0, sent});     // Start bit from this edge
		bus_write(`ADDR_UART_DATA, {24'd0, ~sent});    // Dropped while busy
		bus_read(`ADDR_UART_STATUS, word);
		compare_word("status during frame", 32'd0, word);
		repeat (9) @(negedge clk50);                    // Mid start bit 13.5 cycles in
		compare_word("uart_tx start bit", 32'd0, {31'd0, uart_tx});
		for (bit_num = 0; bit_num < 8; bit_num++)
		begin
			repeat (`UART_BIT_CLOCKS) @(negedge clk50);
			seen[bit_num] = uart_tx;
		end
		repeat (`UART_BIT_CLOCKS) @(negedge clk50);
		compare_word("uart_tx stop bit", 32'd1, {31'd0, uart_tx});
		compare_serial_byte("uart_tx byte", sent, seen);
		bus_read(`ADDR_UART_STATUS, word);              // Still inside the stop bit
		compare_word("status in stop bit", 32'd0, word);
		wait_status(2'b01, "tx_ready");
		bus_read(`ADDR_UART_STATUS, word);
		compare_word("status after frame", 32'd1, word);
	endtask

	task automatic test_uart_rx();
		logic [7:0] sent;
		logic [`IO_DATA_WIDTH-1:0] word;
		int n;
		for (n = 0; n < 4; n++)
		begin
			sent = 8'($random(seed));
			send_frame(sent, 1'b1);
			wait_status(2'b10, "rx_ready");
			bus_read(`ADDR_UART_DATA, word);    // Clears rx_ready
			compare_serial_byte("received byte", sent, word[7:0]);
			bus_read(`ADDR_UART_STATUS, word);
			compare_word("status after data read", 32'd1, word);
		end
		send_frame(8'($random(seed)), 1'b0);    // Framing error
		repeat (2 * `UART_BIT_CLOCKS) @(negedge clk50);
		bus_read(`ADDR_UART_STATUS, word);
		compare_word("status after bad stop bit", 32'd1, word);
	endtask

	initial
	begin
		seed = 83;
		errors = 0;
		timeouts = 0;
		io_req = '0;
		uart_rx = 1'b1;    // Idle line
		core_reset = 1'b1;
		repeat (5) @(negedge clk50);
		core_reset = 1'b0;
		test_reset();
		test_display();
		test_timer();
		test_uart_tx();
		test_uart_rx();
		end_run();
	end

endmodule

/* test/fpga_io_checker.sv */
`timescale 1ns/100ps
`include "fpga_io_macros.svh"

module fpga_io_checker(
	input logic clk50,
	input logic core_reset,
	input fpga_io_pkg::io_req_t io_req,
	input logic [`IO_DATA_WIDTH-1:0] io_read_data,
	input logic [`RED_LED_WIDTH-1:0] red_led,
	input logic uart_tx,
	input logic tx_busy                // Transmitter level from inside uart_port
);

	logic unmapped;    // Address hits no register
	int failures = 0;    // Assertion failures seen so far

	assign unmapped = !(io_req.address inside {`ADDR_RED_LED, `ADDR_GREEN_LED, `ADDR_HEX0,
		`ADDR_HEX1, `ADDR_HEX2, `ADDR_HEX3, `ADDR_UART_STATUS, `ADDR_UART_DATA, `ADDR_TIMER});

	// Idle line sits at the stop level
	idle_line_high: assert property (@(posedge clk50) disable iff (core_reset)
		!tx_busy |-> uart_tx)
		else
		begin
			failures++;
			$error("uart_tx low while the transmitter is idle");
		end

	red_led_on_write: assert property (@(posedge clk50) disable iff (core_reset)
		red_led != $past(red_led) |-> $past(io_req.write_en && io_req.address == `ADDR_RED_LED))
		else
		begin
			failures++;
			$error("red_led changed without a write to its address");
		end

	unmapped_read_zero: assert property (@(posedge clk50) disable iff (core_reset)
		io_req.read_en && unmapped |-> io_read_data == '0)
		else
		begin
			failures++;
			$error("read of unmapped address %h returned %h", io_req.address, io_read_data);
		end

endmodule

bind fpga_io_top fpga_io_checker checker0(.clk50, .core_reset, .io_req, .io_read_data,
	.red_led, .uart_tx, .tx_busy(uart_port0.tx_busy));

/* logic/fpga_io_top.sv */
`timescale 1ns/100ps
`include "fpga_io_macros.svh"

module fpga_io_top(
	input logic clk50,
	input logic core_reset,
	input fpga_io_pkg::io_req_t io_req,          // Bus from the core
	output logic [`IO_DATA_WIDTH-1:0] io_read_data,

	// LEDs and seven-segment digits
	output logic [`RED_LED_WIDTH-1:0] red_led,
	output logic [`GREEN_LED_WIDTH-1:0] green_led,
	output logic [`HEX_WIDTH-1:0] hex0,
	output logic [`HEX_WIDTH-1:0] hex1,
	output logic [`HEX_WIDTH-1:0] hex2,
	output logic [`HEX_WIDTH-1:0] hex3,

	// Serial pins
	output logic uart_tx,
	input logic uart_rx
);

	logic [`IO_DATA_WIDTH-1:0] uart_read_data;   // Merged into io_read_data

	board_registers board_registers0(
		.clk50,
		.core_reset,
		.io_req,
		.uart_read_data,
		.io_read_data,
		.red_led,
		.green_led,
		.hex0,
		.hex1,
		.hex2,
		.hex3);

	uart_port uart_port0(
		.clk50,
		.core_reset,
		.io_req,
		.uart_read_data,
		.uart_tx,
		.uart_rx);

endmodule

/* logic/uart_port.sv */
`timescale 1ns/100ps
`include "fpga_io_macros.svh"

module uart_port(
	input logic clk50,
	input logic core_reset,
	input fpga_io_pkg::io_req_t io_req,
	output logic [`IO_DATA_WIDTH-1:0] uart_read_data,
	output logic uart_tx,
	input logic uart_rx
);

	logic tx_start;
	logic tx_busy;
	logic rx_valid;
	logic [7:0] rx_byte;
	logic [7:0] rx_hold;                   // Last received byte
	logic rx_ready;                        // Unread byte in rx_hold
	logic data_sel;
	fpga_io_pkg::uart_status_t status;

	assign data_sel = io_req.address == `ADDR_UART_DATA;

	// Writes while busy are dropped
	assign tx_start = io_req.write_en && data_sel && !tx_busy;

	assign status.rx_ready = rx_ready;
	assign status.tx_ready = !tx_busy;

	always_ff @(posedge clk50 or posedge core_reset)
	begin
		if (core_reset)
			rx_ready <= 1'b0;
		else if (rx_valid)
			rx_ready <= 1'b1;              // New byte wins over a same-cycle read
		else if (io_req.read_en && data_sel)
			rx_ready <= 1'b0;              // Consumed by the core
	end

	// Unread byte simply overwritten
	always_ff @(posedge clk50)
	begin
		if (rx_valid)
			rx_hold <= rx_byte;
	end

	always_comb
	begin
		uart_read_data = '0;               // Zero outside UART range
		if (io_req.address == `ADDR_UART_STATUS)
			uart_read_data[$bits(status)-1:0] = status;
		else if (data_sel)
			uart_read_data[7:0] = rx_hold;
	end

	uart_transmitter transmitter0(.clk50, .core_reset, .tx_start,
		.tx_byte(io_req.write_data[7:0]), .tx_busy, .uart_tx);

	uart_receiver receiver0(.clk50, .core_reset, .uart_rx, .rx_valid, .rx_byte);

endmodule

/* logic/uart_receiver.sv */
`timescale 1ns/100ps
`include "fpga_io_macros.svh"

module uart_receiver(
	input logic clk50,
	input logic core_reset,
	input logic uart_rx,
	output logic rx_valid,
	output logic [7:0] rx_byte
);

	localparam logic [`UART_COUNT_WIDTH-1:0] half_bit = `UART_BIT_CLOCKS / 2;
	localparam logic [`UART_COUNT_WIDTH-1:0] full_bit = `UART_BIT_CLOCKS - 1;
	localparam logic [3:0] stop_index = 4'd9;

	logic rx_meta;                               // First sync stage
	logic rx_sync;                               // Safe to use
	logic rx_prev;                               // For edge detect
	logic rx_busy;                               // Inside a frame
	logic [`UART_COUNT_WIDTH-1:0] bit_count;     // Down-count to next sample
	logic [3:0] bit_index;                       // 0 start, 1-8 data, 9 stop
	logic [7:0] shift_reg;
	logic sample_now;

	assign sample_now = rx_busy && bit_count == '0;

	always_ff @(posedge clk50 or posedge core_reset)
	begin
		if (core_reset)
		begin
			rx_meta <= 1'b1;    // Assume idle line
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
			rx_busy <= 1'b0;
			bit_count <= '0;
			bit_index <= '0;
		end
		else
		begin
			rx_meta <= uart_rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
			if (!rx_busy)
			begin
				if (rx_prev && !rx_sync)
				begin
					rx_busy <= 1'b1;           // Falling edge, start bit begins
					bit_count <= half_bit;     // First sample at mid start bit
					bit_index <= '0;
				end
			end
			else if (sample_now)
			begin
				bit_count <= full_bit;         // Next mid-bit one bit time on
				bit_index <= bit_index + 1'b1;
				if (bit_index == '0 && rx_sync)
					rx_busy <= 1'b0;           // Glitch, start bit gone high
				if (bit_index == stop_index)
					rx_busy <= 1'b0;           // Frame over, good stop or not
			end
			else
				bit_count <= bit_count - 1'b1;
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge clk50)
	begin
		if (sample_now && bit_index != '0 && bit_index != stop_index)
			shift_reg <= {rx_sync, shift_reg[7:1]};
	end

	// Pulse in the stop-bit sample cycle, bad framing drops the byte
	assign rx_valid = sample_now && bit_index == stop_index && rx_sync;
	assign rx_byte = shift_reg;

endmodule

/* logic/uart_transmitter.sv */
`timescale 1ns/100ps
`include "fpga_io_macros.svh"

module uart_transmitter(
	input logic clk50,
	input logic core_reset,
	input logic tx_start,
	input logic [7:0] tx_byte,
	output logic tx_busy,
	output logic uart_tx
);

	localparam logic [`UART_COUNT_WIDTH-1:0] last_count = `UART_BIT_CLOCKS - 1;
	localparam logic [3:0] stop_index = 4'd9;    // Start, 8 data, stop

	logic [9:0] shift_reg;                       // Frame, LSB goes out first
	logic [`UART_COUNT_WIDTH-1:0] bit_count;     // Clocks within current bit
	logic [3:0] bit_index;                       // Which frame bit is on the line

	always_ff @(posedge clk50 or posedge core_reset)
	begin
		if (core_reset)
		begin
			shift_reg <= '1;     // Line idles high
			bit_count <= '0;
			bit_index <= '0;
			tx_busy <= 1'b0;
		end
		else if (!tx_busy)
		begin
			if (tx_start)
			begin
				shift_reg <= {1'b1, tx_byte, 1'b0};    // Stop, data, start
				bit_count <= '0;
				bit_index <= '0;
				tx_busy <= 1'b1;
			end
		end
		else if (bit_count == last_count)
		begin
			// End of one bit time, move to the next bit
			bit_count <= '0;
			shift_reg <= {1'b1, shift_reg[9:1]};   // Back-fill with idle level
			bit_index <= bit_index + 1'b1;
			if (bit_index == stop_index)
				tx_busy <= 1'b0;                   // Stop bit done
		end
		else
			bit_count <= bit_count + 1'b1;
	end

	// All ones in the shifter when idle keeps the line high
	assign uart_tx = shift_reg[0];

endmodule

/* logic/board_registers.sv */
`timescale 1ns/100ps
`include "fpga_io_macros.svh"

module board_registers(
	input logic clk50,
	input logic core_reset,
	input fpga_io_pkg::io_req_t io_req,
	input logic [`IO_DATA_WIDTH-1:0] uart_read_data,
	output logic [`IO_DATA_WIDTH-1:0] io_read_data,
	output logic [`RED_LED_WIDTH-1:0] red_led,
	output logic [`GREEN_LED_WIDTH-1:0] green_led,
	output logic [`HEX_WIDTH-1:0] hex0,
	output logic [`HEX_WIDTH-1:0] hex1,
	output logic [`HEX_WIDTH-1:0] hex2,
	output logic [`HEX_WIDTH-1:0] hex3
);

	logic [`IO_DATA_WIDTH-1:0] timer_val;    // Free-running cycle count
	logic [`IO_DATA_WIDTH-1:0] board_data;   // Read word from this block only

	always_ff @(posedge clk50 or posedge core_reset)
	begin
		if (core_reset)
		begin
			red_led <= '0;        // Displays dark out of reset
			green_led <= '0;
			hex0 <= '0;
			hex1 <= '0;
			hex2 <= '0;
			hex3 <= '0;
			timer_val <= '0;      // Timer starts from zero
		end
		else
		begin
			timer_val <= timer_val + 1'b1;    // Wraps silently
			if (io_req.write_en)
			begin
				// Upper write bits dropped per register width
				case (io_req.address)
					`ADDR_RED_LED: red_led <= io_req.write_data[`RED_LED_WIDTH-1:0];
					`ADDR_GREEN_LED: green_led <= io_req.write_data[`GREEN_LED_WIDTH-1:0];
					`ADDR_HEX0: hex0 <= io_req.write_data[`HEX_WIDTH-1:0];
					`ADDR_HEX1: hex1 <= io_req.write_data[`HEX_WIDTH-1:0];
					`ADDR_HEX2: hex2 <= io_req.write_data[`HEX_WIDTH-1:0];
					`ADDR_HEX3: hex3 <= io_req.write_data[`HEX_WIDTH-1:0];
					default: ;    // Other addresses ignored here
				endcase
			end
		end
	end

	// Only the timer reads back, display regs are write-only
	always_comb
	begin
		case (io_req.address)
			`ADDR_TIMER: board_data = timer_val;
			default: board_data = '0;
		endcase
	end

	// UART block returns zero outside its own range, so OR merges cleanly
	assign io_read_data = board_data | uart_read_data;

endmodule

/* logic/fpga_io_pkg.sv */
`include "fpga_io_macros.svh"

package fpga_io_pkg;

	// One request from the core's I/O port
	typedef struct packed {
		logic write_en;                           // Single-cycle write strobe
		logic read_en;                            // Read strobe, data returned same cycle
		logic [`IO_ADDR_WIDTH-1:0] address;       // Byte address
		logic [`IO_DATA_WIDTH-1:0] write_data;    // Write payload
	} io_req_t;

	// Low bits of the UART status word
	typedef struct packed {
		logic rx_ready;    // Bit 1, byte waiting in holding reg
		logic tx_ready;    // Bit 0, transmitter idle
	} uart_status_t;

endpackage

/* logic/fpga_io_macros.svh */
`ifndef FPGA_IO_MACROS_SVH
`define FPGA_IO_MACROS_SVH

// I/O bus widths
`define IO_ADDR_WIDTH 32
`define IO_DATA_WIDTH 32

// Board register map
`define ADDR_RED_LED     32'h00
`define ADDR_GREEN_LED   32'h04
`define ADDR_HEX0        32'h08
`define ADDR_HEX1        32'h0C
`define ADDR_HEX2        32'h10
`define ADDR_HEX3        32'h14
`define ADDR_TIMER       32'h24

// UART block, base 0x18
`define ADDR_UART_STATUS 32'h18
`define ADDR_UART_DATA   32'h1C

// Display register widths
`define RED_LED_WIDTH    18
`define GREEN_LED_WIDTH  9
`define HEX_WIDTH        7

// Serial timing, 27 clocks per bit
`define UART_BIT_CLOCKS  27
`define UART_COUNT_WIDTH 5   // Holds 0 to UART_BIT_CLOCKS-1

`endif
